// File: dlx_tests.txt
# Columns: instruction word (hex), test name, event kind (wb, st or no),
# expected register or store address (hex), expected value (hex)
20010005 addi_r1      wb 01 00000005
2002FFFD addi_neg_r2  wb 02 FFFFFFFD
00221820 add_r3       wb 03 00000002
00222018 sub_r4       wb 04 00000008
00222826 xor_r5       wb 05 FFFFFFF8
2826FFFE subi_neg_r6  wb 06 00000007
20200009 addi_r0      no 00 00000000
7447FFFC sgei_true    wb 07 00000001
74480000 sgei_false   wb 08 00000000
AC040010 sw_r4        st 10 00000008
8C090010 lw_r9        wb 09 00000008
01215020 add_after_lw wb 0A 0000000D
11000004 beqz_taken   no 00 00000000
200B0077 beqz_shadow  no 00 00000000
15000004 bnez_fall    no 00 00000000
200C0012 fall_r12     wb 0C 00000012
14E00004 bnez_taken   no 00 00000000
200B0066 bnez_shadow  no 00 00000000
08000004 j_fwd        no 00 00000000
200B0055 j_shadow     no 00 00000000
200D0064 addi_r13     wb 0D 00000064
31A00000 jr_r13       no 00 00000000
200B0044 jr_shadow    no 00 00000000
200B0033 jr_gap1      no 00 00000000
200B0022 jr_gap2      no 00 00000000
246EFFFF addui_r14    wb 0E 00010001
00417819 subu_r15     wb 0F FFFFFFF8

// File: build.f
+incdir+.
dlx_pkg.sv
dlx_jump_branch.sv
dlx_control.sv
dlx_regfile.sv
dlx_alu.sv
dlx_data_mem.sv
dlx_core.sv
tb_dlx_core.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the DLX core testbench with Verilator

LOG=sim.log

verilator --binary --timing -f build.f --top-module tb_dlx_core -o sim_tb_dlx_core
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

./obj_dir/sim_tb_dlx_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "ERRORS FOUND" "$LOG"; then
   exit 1
fi
exit 0

// File: tb_dlx_core.sv
`timescale 1ns/100ps

module tb_dlx_core;

   localparam int CLK_PERIOD = 40;
   localparam int IMEM_WORDS = 256;
   localparam logic [31:0] NOP_WORD = 32'h0000_0015; // Special opcode, nop function

   logic              clk = 1'b0;
   logic              rst;
   dlx_pkg::instr_t   imem_data;
   dlx_pkg::word_t    imem_addr;
   logic              wb_valid;
   dlx_pkg::reg_idx_t wb_reg;
   dlx_pkg::word_t    wb_data;
   logic              st_valid;
   dlx_pkg::word_t    st_addr;
   dlx_pkg::word_t    st_data;

   logic [31:0]       imem [IMEM_WORDS];
   logic [8*16-1:0]   exp_name [IMEM_WORDS];
   logic              exp_is_st [IMEM_WORDS];
   logic [31:0]       exp_where [IMEM_WORDS]; // Register index or store address
   logic [31:0]       exp_value [IMEM_WORDS];

   int   prog_len    = 0;
   int   n_events    = 0;
   int   ev_idx      = 0;
   int   pass_count  = 0;
   int   fail_count  = 0;
   int   load_errors = 0;
   int   run_cycles  = 0;
   logic loaded      = 1'b0;

   dlx_core dut (
      .clk       (clk),
      .rst       (rst),
      .imem_data (imem_data),
      .imem_addr (imem_addr),
      .wb_valid  (wb_valid),
      .wb_reg    (wb_reg),
      .wb_data   (wb_data),
      .st_valid  (st_valid),
      .st_addr   (st_addr),
      .st_data   (st_data)
   );

   always #(CLK_PERIOD/2) clk = ~clk;

   task automatic load_tests();
      int              fd;
      int              n;
      string           line;
      logic [31:0]     word;
      logic [8*16-1:0] name;
      logic [15:0]     kind;
      logic [31:0]     where;
      logic [31:0]     value;
      fd = $fopen("dlx_tests.txt", "r");
      if (fd == 0) begin
         $display("Could not open dlx_tests.txt");
         load_errors++;
      end else begin
         while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line.getc(0) != "#" && prog_len < IMEM_WORDS) begin
               n = $sscanf(line, "%h %s %s %h %h", word, name, kind, where, value);
               if (n != 5) begin
                  $display("Malformed line in dlx_tests.txt: %s", line);
                  load_errors++;
               end else begin
                  imem[prog_len] = word;
                  prog_len++;
                  if (kind != "no") begin // Line produces an event
                     exp_name[n_events]  = name;
                     exp_is_st[n_events] = (kind == "st");
                     exp_where[n_events] = where;
                     exp_value[n_events] = value;
                     n_events++;
                  end
               end
            end
         end
         $fclose(fd);
      end
   endtask

   function automatic logic [31:0] fetch_word(input logic [31:0] addr);
      logic [31:0] idx;
      idx = addr >> 2;
      if (idx < prog_len) begin
         return imem[idx[7:0]];
      end
      return NOP_WORD; // Past the program end
   endfunction

   task check_event(input logic is_st, input logic [31:0] where, input logic [31:0] value);
      if (ev_idx >= n_events) begin
         $display("Unexpected extra %s event at %h with value %h", is_st ? "st" : "wb",
                  where, value);
         fail_count++;
      end else begin
         if (exp_is_st[ev_idx] != is_st) begin
            $display("Test %0s expected a %s event but the DUT produced a %s event",
                     exp_name[ev_idx], exp_is_st[ev_idx] ? "st" : "wb", is_st ? "st" : "wb");
            fail_count++;
         end else if (exp_where[ev_idx] != where || exp_value[ev_idx] != value) begin
            $display("FAILED %0s expected %h/%h actual %h/%h", exp_name[ev_idx],
                     exp_where[ev_idx], exp_value[ev_idx], where, value);
            fail_count++;
         end else begin
            $display("ok %0s", exp_name[ev_idx]);
            pass_count++;
         end
         ev_idx++;
      end
   endtask

   initial begin
      imem_data = NOP_WORD;
      forever begin
         @(posedge clk);
         #1 imem_data = fetch_word(imem_addr); // Combinational fetch
      end
   end

   always @(posedge clk) begin
      if (!rst) begin
         run_cycles++;
      end
   end

   // Outputs are settled by the falling edge
   always @(negedge clk) begin
      if (wb_valid || st_valid) begin
         if (rst || run_cycles < 1) begin
            $display("Event seen during reset or in the first cycle after it");
            fail_count++;
         end else begin
            if (wb_valid) begin
               check_event(1'b0, {27'b0, wb_reg}, wb_data); // Older instruction first
            end
            if (st_valid) begin
               check_event(1'b1, st_addr, st_data);
            end
         end
      end
   end

   initial begin
      wait (loaded);
      #(CLK_PERIOD * (4 * prog_len + 20));
      $display("Timeout with %0d of %0d expected events never seen", n_events - ev_idx,
               n_events);
      $display("ERRORS FOUND");
      $finish;
   end

   initial begin
      rst = 1'b1;
      load_tests();
      loaded = 1'b1;
      repeat (2) @(posedge clk);
      #1 rst = 1'b0;
      while (ev_idx < n_events) begin
         @(posedge clk);
      end
      repeat (8) @(posedge clk); // Catch trailing extra events
      $display("Closing counts: %0d passed, %0d failed", pass_count,
               fail_count + load_errors);
      if (fail_count == 0 && load_errors == 0 && n_events > 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

// File: dlx_core.sv
`timescale 1ns/100ps
`include "dlx_macros.svh"

module dlx_core (
   input  logic              clk,
   input  logic              rst,
   input  dlx_pkg::instr_t   imem_data,
   output dlx_pkg::word_t    imem_addr,
   output logic              wb_valid,
   output dlx_pkg::reg_idx_t wb_reg,
   output dlx_pkg::word_t    wb_data,
   output logic              st_valid,
   output dlx_pkg::word_t    st_addr,
   output dlx_pkg::word_t    st_data
);

   dlx_pkg::word_t      pc;
   dlx_pkg::word_t      pc_plus_four;
   dlx_pkg::instr_t     dec_instr;
   dlx_pkg::word_t      dec_pc_plus_four;
   dlx_pkg::kill_state_t kill_state;

   logic                reg_wr;
   dlx_pkg::reg_idx_t   reg_dst;
   dlx_pkg::reg_idx_t   rs1_sel;
   dlx_pkg::reg_idx_t   rs2_sel;
   logic                ext_op;
   logic                alu_src;
   dlx_pkg::alu_op_t    alu_op;
   logic                mem_wr;
   logic                mem_to_reg;
   logic                branch;
   dlx_pkg::word_t      new_pc_if_jump;
   logic                kill_next;

   dlx_pkg::word_t      rs1_val;
   dlx_pkg::word_t      rs2_val;
   dlx_pkg::word_t      imm_ext;
   dlx_pkg::word_t      alu_b;
   dlx_pkg::word_t      alu_result;
   dlx_pkg::word_t      mem_rd_data;

   logic                wb_load;
   dlx_pkg::word_t      wb_alu;
   logic                load_wr;
   logic                rf_wr_en;
   dlx_pkg::reg_idx_t   rf_wr_sel;
   dlx_pkg::word_t      rf_wr_data;

   assign pc_plus_four = pc + 32'd4;
   assign imem_addr    = pc;

   always_ff @(posedge clk) begin
      if (rst) begin
         pc         <= '0;
         kill_state <= dlx_pkg::ks_kill; // Empty decode reg is squashed
         wb_valid   <= 1'b0;
         wb_load    <= 1'b0;
      end else begin
         if (branch) begin
            pc <= new_pc_if_jump;
         end else if (mem_to_reg) begin
            pc <= dec_pc_plus_four; // Refetch the load's follower
         end else begin
            pc <= pc_plus_four;
         end
         kill_state <= kill_next ? dlx_pkg::ks_kill : dlx_pkg::ks_run;
         wb_valid   <= reg_wr && (reg_dst != '0); // r0 never reported
         wb_load    <= mem_to_reg;
      end
   end

   always_ff @(posedge clk) begin
      dec_instr        <= imem_data;
      dec_pc_plus_four <= pc_plus_four;
      wb_reg           <= reg_dst;
      wb_alu           <= alu_result;
   end

   dlx_control u_control (
      .instr            (dec_instr),
      .rs1              (rs1_val),
      .pc_plus_four     (dec_pc_plus_four),
      .should_be_killed (kill_state == dlx_pkg::ks_kill),
      .reg_wr           (reg_wr),
      .reg_dst          (reg_dst),
      .rs1_sel          (rs1_sel),
      .rs2_sel          (rs2_sel),
      .ext_op           (ext_op),
      .alu_src          (alu_src),
      .alu_op           (alu_op),
      .mem_wr           (mem_wr),
      .mem_to_reg       (mem_to_reg),
      .branch           (branch),
      .new_pc_if_jump   (new_pc_if_jump),
      .kill_next        (kill_next)
   );

   // ALU results write at the decode edge, loads one edge later
   assign load_wr    = wb_valid && wb_load;
   assign rf_wr_en   = load_wr || (reg_wr && !mem_to_reg);
   assign rf_wr_sel  = load_wr ? wb_reg : reg_dst;
   assign rf_wr_data = load_wr ? wb_data : alu_result;

   dlx_regfile u_regfile (
      .clk      (clk),
      .rst      (rst),
      .rs1_sel  (rs1_sel),
      .rs2_sel  (rs2_sel),
      .wr_sel   (rf_wr_sel),
      .wr_en    (rf_wr_en),
      .wr_data  (rf_wr_data),
      .rs1_data (rs1_val),
      .rs2_data (rs2_val)
   );

   assign imm_ext = ext_op ? {{(`DLX_WORD_W-16){dec_instr[16]}}, dec_instr[16:31]}
                           : {{(`DLX_WORD_W-16){1'b0}}, dec_instr[16:31]};
   assign alu_b   = alu_src ? rs2_val : imm_ext;

   dlx_alu u_alu (
      .a      (rs1_val),
      .b      (alu_b),
      .op     (alu_op),
      .result (alu_result)
   );

   dlx_data_mem u_data_mem (
      .clk     (clk),
      .addr    (alu_result),
      .wr_en   (mem_wr),
      .wr_data (rs2_val),
      .rd_data (mem_rd_data)
   );

   assign wb_data  = wb_load ? mem_rd_data : wb_alu;

   assign st_valid = mem_wr;
   assign st_addr  = alu_result;
   assign st_data  = rs2_val;

endmodule

// File: dlx_data_mem.sv
`timescale 1ns/100ps
`include "dlx_macros.svh"

module dlx_data_mem (
   input  logic           clk,
   input  dlx_pkg::word_t addr,
   input  logic           wr_en,
   input  dlx_pkg::word_t wr_data,
   output dlx_pkg::word_t rd_data
);

   localparam int IDX_W = $clog2(`DLX_DMEM_WORDS);

   dlx_pkg::word_t   mem [`DLX_DMEM_WORDS];
   logic [IDX_W-1:0] idx;

   assign idx = addr[IDX_W+1:2]; // Drop byte offset

   initial begin
      for (int i = 0; i < `DLX_DMEM_WORDS; i++) begin
         mem[i] = '0;
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[idx] <= wr_data;
      end
      rd_data <= mem[idx];
   end

endmodule

// File: dlx_alu.sv
`timescale 1ns/100ps
`include "dlx_macros.svh"

module dlx_alu (
   input  dlx_pkg::word_t   a,
   input  dlx_pkg::word_t   b,
   input  dlx_pkg::alu_op_t op,
   output dlx_pkg::word_t   result
);

   logic sge;

   assign sge = ($signed(a) >= $signed(b)); // Signed compare

   always_comb begin
      case (op)
         `DLX_ALU_ADD: begin
            result = a + b;
         end
         `DLX_ALU_SUB: begin
            result = a - b;
         end
         `DLX_ALU_XOR: begin
            result = a ^ b;
         end
         `DLX_ALU_SGE: begin
            result = {{(`DLX_WORD_W-1){1'b0}}, sge}; // 1 or 0
         end
         default: begin
            result = '0;
         end
      endcase
   end

endmodule

// File: dlx_regfile.sv
`timescale 1ns/100ps
`include "dlx_macros.svh"

module dlx_regfile (
   input  logic              clk,
   input  logic              rst,
   input  dlx_pkg::reg_idx_t rs1_sel,
   input  dlx_pkg::reg_idx_t rs2_sel,
   input  dlx_pkg::reg_idx_t wr_sel,
   input  logic              wr_en,
   input  dlx_pkg::word_t    wr_data,
   output dlx_pkg::word_t    rs1_data,
   output dlx_pkg::word_t    rs2_data
);

   dlx_pkg::word_t regs [1:`DLX_REG_COUNT-1]; // No storage for r0

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 1; i < `DLX_REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en && wr_sel != '0) begin
         regs[wr_sel] <= wr_data;
      end
   end

   assign rs1_data = (rs1_sel == '0) ? '0 : regs[rs1_sel];
   assign rs2_data = (rs2_sel == '0) ? '0 : regs[rs2_sel];

endmodule

// File: dlx_control.sv
`timescale 1ns/100ps
`include "dlx_macros.svh"

module dlx_control (
   input  dlx_pkg::instr_t   instr,
   input  dlx_pkg::word_t    rs1,
   input  dlx_pkg::word_t    pc_plus_four,
   input  logic              should_be_killed,
   output logic              reg_wr,
   output dlx_pkg::reg_idx_t reg_dst,
   output dlx_pkg::reg_idx_t rs1_sel,
   output dlx_pkg::reg_idx_t rs2_sel,
   output logic              ext_op,
   output logic              alu_src,
   output dlx_pkg::alu_op_t  alu_op,
   output logic              mem_wr,
   output logic              mem_to_reg,
   output logic              branch,
   output dlx_pkg::word_t    new_pc_if_jump,
   output logic              kill_next
);

   logic [0:5] opcode;
   logic [0:5] func;
   logic       r_type;
   logic       r_alu;
   logic       i_alu;
   logic       is_lw;
   logic       take_branch;

   assign opcode  = instr[0:5];
   assign func    = instr[26:31];
   assign rs1_sel = instr[6:10];
   assign rs2_sel = instr[11:15];

   assign r_type = (opcode == `DLX_OP_SPECIAL) && (func != `DLX_FN_NOP);

   // Only the supported R-type functions write back
   assign r_alu = r_type && (func == `DLX_FN_ADD  || func == `DLX_FN_ADDU ||
                             func == `DLX_FN_SUB  || func == `DLX_FN_SUBU ||
                             func == `DLX_FN_XOR);

   assign i_alu = opcode == `DLX_OP_ADDI || opcode == `DLX_OP_ADDUI ||
                  opcode == `DLX_OP_SUBI || opcode == `DLX_OP_SUBUI ||
                  opcode == `DLX_OP_SGEI;

   assign is_lw = (opcode == `DLX_OP_LW);

   assign reg_dst = r_type ? instr[16:20] : instr[11:15]; // rd or rs2 field

   assign ext_op = opcode == `DLX_OP_ADDI || opcode == `DLX_OP_SUBI ||
                   opcode == `DLX_OP_SGEI || opcode == `DLX_OP_LW ||
                   opcode == `DLX_OP_SW; // Unsigned forms zero extend

   assign alu_src = r_type; // 1 selects rs2, 0 the immediate

   always_comb begin
      alu_op = `DLX_ALU_ADD; // Address calc for lw/sw
      case (opcode)
         `DLX_OP_SPECIAL: begin
            case (func)
               `DLX_FN_SUB, `DLX_FN_SUBU: alu_op = `DLX_ALU_SUB;
               `DLX_FN_XOR:               alu_op = `DLX_ALU_XOR;
               default:                   alu_op = `DLX_ALU_ADD;
            endcase
         end
         `DLX_OP_SUBI, `DLX_OP_SUBUI: alu_op = `DLX_ALU_SUB;
         `DLX_OP_SGEI:                alu_op = `DLX_ALU_SGE;
         default:                     alu_op = `DLX_ALU_ADD;
      endcase
   end

   dlx_jump_branch u_jump_branch (
      .instruction  (instr),
      .pc_plus_four (pc_plus_four),
      .rs1          (rs1),
      .output_pc    (new_pc_if_jump),
      .take_branch  (take_branch)
   );

   assign reg_wr     = (r_alu || i_alu || is_lw) && !should_be_killed;
   assign mem_wr     = (opcode == `DLX_OP_SW) && !should_be_killed;
   assign mem_to_reg = is_lw && !should_be_killed;
   assign branch     = take_branch && !should_be_killed;

   // Load refetches its follower, redirect drops it
   assign kill_next = mem_to_reg || branch;

endmodule

// File: dlx_jump_branch.sv
`timescale 1ns/100ps
`include "dlx_macros.svh"

module dlx_jump_branch (
   input  dlx_pkg::instr_t instruction,
   input  dlx_pkg::word_t  pc_plus_four,
   input  dlx_pkg::word_t  rs1,
   output dlx_pkg::word_t  output_pc,
   output logic            take_branch
);

   logic [0:5]     opcode;
   dlx_pkg::word_t off16;
   dlx_pkg::word_t off26;
   logic           rs1_zero;

   assign opcode   = instruction[0:5];
   assign off16    = {{(`DLX_WORD_W-16){instruction[16]}}, instruction[16:31]};
   assign off26    = {{(`DLX_WORD_W-26){instruction[6]}}, instruction[6:31]};
   assign rs1_zero = (rs1 == '0);

   always_comb begin
      output_pc   = pc_plus_four + off16; // Branch target by default
      take_branch = 1'b0;
      case (opcode)
         `DLX_OP_J: begin
            output_pc   = pc_plus_four + off26;
            take_branch = 1'b1;
         end
         `DLX_OP_JR: begin
            output_pc   = rs1; // Register indirect
            take_branch = 1'b1;
         end
         `DLX_OP_BEQZ: take_branch = rs1_zero;
         `DLX_OP_BNEZ: take_branch = ~rs1_zero;
         default: take_branch = 1'b0;
      endcase
   end

endmodule

// File: dlx_pkg.sv
`include "dlx_macros.svh"

package dlx_pkg;

   typedef logic [`DLX_WORD_W-1:0] word_t;

   // Bit 0 is the MSB, matching DLX field numbering
   typedef logic [0:`DLX_WORD_W-1] instr_t;

   typedef logic [$clog2(`DLX_REG_COUNT)-1:0] reg_idx_t;

   typedef logic [`DLX_ALU_OP_W-1:0] alu_op_t;

   // Whether the instruction sitting in decode is squashed
   typedef enum logic {
      ks_run,
      ks_kill
   } kill_state_t;

endpackage

// File: dlx_macros.svh
`ifndef DLX_MACROS_SVH
`define DLX_MACROS_SVH

`define DLX_WORD_W     32
`define DLX_REG_COUNT  32
`define DLX_DMEM_WORDS 64
`define DLX_ALU_OP_W   5

// Major opcodes, instr[0:5]
`define DLX_OP_SPECIAL 6'h00
`define DLX_OP_J       6'h02
`define DLX_OP_BEQZ    6'h04
`define DLX_OP_BNEZ    6'h05
`define DLX_OP_ADDI    6'h08
`define DLX_OP_ADDUI   6'h09
`define DLX_OP_SUBI    6'h0a
`define DLX_OP_SUBUI   6'h0b
`define DLX_OP_JR      6'h0c
`define DLX_OP_SGEI    6'h1d
`define DLX_OP_LW      6'h23
`define DLX_OP_SW      6'h2b

// R-type function codes, instr[26:31]
`define DLX_FN_ADD     6'h20
`define DLX_FN_ADDU    6'h21
`define DLX_FN_SUB     6'h18
`define DLX_FN_SUBU    6'h19
`define DLX_FN_XOR     6'h26
`define DLX_FN_NOP     6'h15

`define DLX_ALU_AND    5'h00
`define DLX_ALU_OR     5'h01
`define DLX_ALU_ADD    5'h02 // Also addu
`define DLX_ALU_SUB    5'h03 // Also subu
`define DLX_ALU_XOR    5'h04
`define DLX_ALU_SGE    5'h09

`endif
